//--- src/stats_defs.svh
`ifndef STATS_DEFS_SVH
`define STATS_DEFS_SVH

// Width of every statistics counter and of the read data returned to software
// A small width keeps the carry into the high half within reach of a short test
// The counter splits this width in two, so it should be even
`define STATS_COUNTER_BITS 16

// Number of counters kept by the block
// The counter index enum in the package names exactly this many entries
`define STATS_NUM_COUNTERS 4

`endif

//--- src/stats_pkg.sv
`include "stats_defs.svh"

`default_nettype none

package stats_pkg;

    // One request event as seen by the request monitor
    // At most one event is presented per cycle
    typedef struct packed {
        // Strobe for exactly one cycle per event
        logic       valid;
        // High for a write, low for a read
        logic       is_write;
        // Line count minus one, so codes 0 to 3 stand for 1 to 4 lines
        logic [1:0] num_lines;
    } stats_req_t;

    // Per-cycle increments for the four counters
    // Each field holds at most 4, which fits in 3 bits
    typedef struct packed {
        logic [2:0] read_reqs;
        logic [2:0] write_reqs;
        logic [2:0] read_lines;
        logic [2:0] write_lines;
    } stats_incr_t;

    // Software names for the counters, used as the read index
    typedef enum logic [1:0] {
        READ_REQS   = 2'd0,
        WRITE_REQS  = 2'd1,
        READ_LINES  = 2'd2,
        WRITE_LINES = 2'd3
    } stats_counter_idx_e;

    // Registered answer to a software read
    typedef struct packed {
        logic                           valid;
        logic [`STATS_COUNTER_BITS-1:0] data;
    } stats_rd_rsp_t;

endpackage

`default_nettype wire

//--- src/stats_counter_multicycle.sv
`include "stats_defs.svh"

`default_nettype none

// Accumulating counter split into two pipeline stages
// The first stage adds the increment to the low half and keeps the carry out
// The second stage folds that carry into the high half of value
// The carry chain is thus only half as long, and value lags the input by one cycle
module stats_counter_multicycle
#(
    parameter int num_bits = `STATS_COUNTER_BITS
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic [num_bits-1:0] incr_by,
    output logic [num_bits-1:0] value
);

    localparam int half_bits = num_bits / 2;

    // First stage state
    logic [half_bits-1:0] low_half;
    logic                 carry;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            low_half <= '0;
            carry    <= 1'b0;
            value    <= '0;
        end
        else
        begin
            // Only the low half of incr_by is summed
            // Callers keep increments below half the counter width
            {carry, low_half} <= low_half + incr_by[half_bits-1:0];

            // Second stage copies the low half and ripples the stored carry upward
            value[half_bits-1:0]        <= low_half;
            value[num_bits-1:half_bits] <= value[num_bits-1:half_bits] + carry;
        end
    end

endmodule

`default_nettype wire

//--- src/stats_event_decode.sv
`default_nettype none

// Turns one request event into the increments for all four counters
// The result is registered, so incr shows an event one cycle after it is sampled
module stats_event_decode
(
    input  logic                    clk,
    input  logic                    reset,
    input  stats_pkg::stats_req_t   req,
    output stats_pkg::stats_incr_t  incr
);

    import stats_pkg::*;

    // Combinational increments for the event on req this cycle
    stats_incr_t incr_next;

    // Number of lines carried by the event
    // The code is one less than the count, so the range 1 to 4 fits in 3 bits
    logic [2:0] line_count;

    assign line_count = {1'b0, req.num_lines} + 3'd1;

    always_comb
    begin
        // Fields stay zero unless the event selects them
        incr_next = '0;

        if (req.valid)
        begin
            if (req.is_write)
            begin
                incr_next.write_reqs  = 3'd1;
                incr_next.write_lines = line_count;
            end
            else
            begin
                incr_next.read_reqs  = 3'd1;
                incr_next.read_lines = line_count;
            end
        end
    end

    // Register stage
    // An idle cycle loads all zeros, so a counter only moves on a real event
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            incr <= '0;
        end
        else
        begin
            incr <= incr_next;
        end
    end

endmodule

`default_nettype wire

//--- src/stats_csr_read.sv
`include "stats_defs.svh"

`default_nettype none

// Software read port for the counter values
// A strobe on rd_en returns the indexed counter one cycle later
// Reads may be issued every cycle and each one is answered in order
module stats_csr_read
(
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  rd_en,
    input  stats_pkg::stats_counter_idx_e                         rd_idx,
    input  logic [`STATS_NUM_COUNTERS-1:0][`STATS_COUNTER_BITS-1:0] values,
    output stats_pkg::stats_rd_rsp_t                              rd_rsp
);

    // Counter picked by the current index
    logic [`STATS_COUNTER_BITS-1:0] sel_value;

    // The enum covers every counter, so no index falls outside the array
    assign sel_value = values[rd_idx];

    // Valid strobe copies rd_en one cycle late
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_rsp.valid <= 1'b0;
        end
        else
        begin
            rd_rsp.valid <= rd_en;
        end
    end

    // Data capture
    // The value is taken as it stands at the edge that samples the strobe
    // Between reads the last answer is held
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_rsp.data <= sel_value;
        end
    end

endmodule

`default_nettype wire

//--- src/stats_top.sv
`include "stats_defs.svh"

`default_nettype none

// Memory traffic statistics block
// Request events are decoded into increments, summed by four split-carry counters,
// and read back by software through an indexed port
// An event sampled at edge E is in the counters after E+2
module stats_top
(
    input  logic                          clk,
    input  logic                          reset,
    input  stats_pkg::stats_req_t         req,
    input  logic                          rd_en,
    input  stats_pkg::stats_counter_idx_e rd_idx,
    output stats_pkg::stats_rd_rsp_t      rd_rsp
);

    import stats_pkg::*;

    // Registered increments from the decoder
    stats_incr_t incr;

    // Increments laid out by counter index so that one loop builds all counters
    logic [`STATS_NUM_COUNTERS-1:0][2:0] incr_fields;

    // Current counter values in index order
    logic [`STATS_NUM_COUNTERS-1:0][`STATS_COUNTER_BITS-1:0] values;

    stats_event_decode decode_inst
    (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .incr  (incr)
    );

    assign incr_fields[READ_REQS]   = incr.read_reqs;
    assign incr_fields[WRITE_REQS]  = incr.write_reqs;
    assign incr_fields[READ_LINES]  = incr.read_lines;
    assign incr_fields[WRITE_LINES] = incr.write_lines;

    // One counter per index
    // Each 3-bit increment is zero-extended to the full counter width
    for (genvar i = 0; i < `STATS_NUM_COUNTERS; i++)
    begin : gen_counter
        stats_counter_multicycle #(.num_bits(`STATS_COUNTER_BITS)) counter_inst
        (
            .clk     (clk),
            .reset   (reset),
            .incr_by ({{(`STATS_COUNTER_BITS-3){1'b0}}, incr_fields[i]}),
            .value   (values[i])
        );
    end

    stats_csr_read csr_read_inst
    (
        .clk    (clk),
        .reset  (reset),
        .rd_en  (rd_en),
        .rd_idx (rd_idx),
        .values (values),
        .rd_rsp (rd_rsp)
    );

endmodule

`default_nettype wire

//--- testbench/stats_clock_gen.sv
`default_nettype none

// Free-running clock with a period of 4 time units
// Reset is high over the first two rising edges
module stats_clock_gen
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        // Reset drops on a falling edge, like every other DUT input
        repeat (2) @(negedge clk);
        reset = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/stats_props.sv
`include "stats_defs.svh"

`default_nettype none

// Concurrent checks on the statistics block, attached to stats_top with bind
module stats_props
(
    input logic                                                  clk,
    input logic                                                  reset,
    input logic                                                  rd_en,
    input stats_pkg::stats_rd_rsp_t                              rd_rsp,
    input stats_pkg::stats_incr_t                                incr,
    input logic [`STATS_NUM_COUNTERS-1:0][`STATS_COUNTER_BITS-1:0] values
);

    // The counter only sums the low half of its increment
    // One event adds at most one request and four lines, well inside that half
    incr_in_range: assert property (@(posedge clk) disable iff (reset)
        (incr.read_reqs <= 3'd1) &&
        (incr.write_reqs <= 3'd1) &&
        (incr.read_lines <= 3'd4) &&
        (incr.write_lines <= 3'd4))
        else $error("increment larger than one event can add");

    // Each read strobe is answered on the very next cycle and nothing else is
    rsp_follows_rd_en: assert property (@(posedge clk) disable iff (reset)
        rd_rsp.valid == $past(rd_en))
        else $error("read response valid does not follow rd_en by one cycle");

    // Counters only ever accumulate until the next reset
    for (genvar i = 0; i < `STATS_NUM_COUNTERS; i++)
    begin : gen_monotonic
        value_never_drops: assert property (@(posedge clk) disable iff (reset)
            !$past(reset) |-> values[i] >= $past(values[i]))
            else $error("counter %0d decreased", i);
    end

endmodule

bind stats_top stats_props props_inst
(
    .clk    (clk),
    .reset  (reset),
    .rd_en  (rd_en),
    .rd_rsp (rd_rsp),
    .incr   (incr),
    .values (values)
);

`default_nettype wire

//--- testbench/stats_tb.sv
`include "stats_defs.svh"

`default_nettype none

// Testbench for the memory traffic statistics block
// Commands and expected counter values come from the trace file
// Every DUT input changes on the falling edge of clk
module stats_tb;

    import stats_pkg::*;

    localparam int cnt_bits       = `STATS_COUNTER_BITS;
    localparam int timeout_cycles = 16;

    logic               clk;
    logic               reset;
    stats_req_t         req;
    logic               rd_en;
    stats_counter_idx_e rd_idx;
    stats_rd_rsp_t      rd_rsp;

    // Expected totals built from the counting rules, in counter index order
    logic [cnt_bits-1:0] model [`STATS_NUM_COUNTERS];
    // Expected answers for a burst of reads over all indices
    logic [cnt_bits-1:0] burst_values [`STATS_NUM_COUNTERS];
    logic [31:0]         lfsr_state;
    int                  test_errors;
    int                  total_errors;
    int                  tests_passed;
    int                  tests_failed;
    // A wait that ran out or an unusable trace stops the command loop
    logic                aborted;

    stats_clock_gen clock_gen_inst
    (
        .clk   (clk),
        .reset (reset)
    );

    stats_top stats_top_inst
    (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .rd_en  (rd_en),
        .rd_idx (rd_idx),
        .rd_rsp (rd_rsp)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step for every bit handed out
    task automatic draw_bit(output logic bit_out);
        lfsr_state = lfsr_next(lfsr_state);
        bit_out    = lfsr_state[0];
    endtask

    // One cycle without a read, so no response may show up after it
    task automatic step_cycle(input stats_req_t event_in);
        req   = event_in;
        rd_en = 1'b0;
        @(negedge clk);
        if (rd_rsp.valid)
        begin
            $display("error at %0t: read response valid without a read", $time);
            test_errors++;
        end
    endtask

    // Presents one event and adds it to the expected totals
    task automatic send_request(input logic is_write, input int lines);
        stats_req_t event_in;
        event_in.valid     = 1'b1;
        event_in.is_write  = is_write;
        event_in.num_lines = 2'(lines - 1);
        if (is_write)
        begin
            model[WRITE_REQS]  = model[WRITE_REQS] + cnt_bits'(1);
            model[WRITE_LINES] = model[WRITE_LINES] + cnt_bits'(lines);
        end
        else
        begin
            model[READ_REQS]  = model[READ_REQS] + cnt_bits'(1);
            model[READ_LINES] = model[READ_LINES] + cnt_bits'(lines);
        end
        step_cycle(event_in);
    endtask

    // Back-to-back events, kind first and then the two bits of the length code
    task automatic send_stream(input int count);
        logic       is_write;
        logic [1:0] code;
        for (int n = 0; n < count; n++)
        begin
            draw_bit(is_write);
            draw_bit(code[1]);
            draw_bit(code[0]);
            send_request(is_write, int'(code) + 1);
        end
    endtask

    task automatic check_data(input int idx, input logic [cnt_bits-1:0] expected);
        if (rd_rsp.data !== expected)
        begin
            $display("error at %0t: counter %0d read 0x%0h, expected 0x%0h",
                     $time, idx, rd_rsp.data, expected);
            test_errors++;
        end
    endtask

    // Three quiet cycles let earlier events reach the counters before the read
    task automatic single_read(input int idx, input logic [cnt_bits-1:0] expected);
        int waited;
        repeat (3) step_cycle('0);
        rd_en  = 1'b1;
        rd_idx = stats_counter_idx_e'(idx);
        @(negedge clk);
        rd_en  = 1'b0;
        waited = 1;
        while (!rd_rsp.valid && waited < timeout_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (!rd_rsp.valid)
        begin
            $display("Timed out after %0d cycles waiting for the read of counter %0d",
                     waited, idx);
            test_errors++;
            aborted = 1'b1;
        end
        else if (waited != 1)
        begin
            $display("error at %0t: read of counter %0d answered after %0d cycles",
                     $time, idx, waited);
            test_errors++;
        end
        else
        begin
            check_data(idx, expected);
        end
    endtask

    // Reads every index on consecutive cycles
    // Each answer is due exactly one cycle after its strobe
    task automatic burst_read();
        repeat (3) step_cycle('0);
        for (int i = 0; i < `STATS_NUM_COUNTERS; i++)
        begin
            rd_en  = 1'b1;
            rd_idx = stats_counter_idx_e'(i);
            @(negedge clk);
            if (!rd_rsp.valid)
            begin
                $display("Read of counter %0d in a burst got no response one cycle later", i);
                test_errors++;
            end
            else
            begin
                check_data(i, burst_values[i]);
            end
        end
        rd_en = 1'b0;
    endtask

    task automatic finish_test(input logic [8*32-1:0] name);
        if (test_errors == 0)
        begin
            $display("test %0s passed", name);
            tests_passed++;
        end
        else
        begin
            $display("test %0s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors   = 0;
    endtask

    initial
    begin
        int               fd;
        int               fields;
        int               needed;
        int               waited;
        int               lines;
        int               count;
        int               idx;
        logic [31:0]      value;
        logic [8*16-1:0]  cmd;
        logic [8*32-1:0]  word;
        logic [8*128-1:0] rest;

        req          = '0;
        rd_en        = 1'b0;
        rd_idx       = READ_REQS;
        lfsr_state   = 32'h89bcb335;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        fd           = 0;
        fields       = 0;
        needed       = 0;
        for (int i = 0; i < `STATS_NUM_COUNTERS; i++)
        begin
            model[i] = '0;
        end

        // Reset only changes on a falling edge, so the rising edge sees it stable
        waited = 0;
        @(posedge clk);
        while (reset && waited < timeout_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        if (reset)
        begin
            $display("Reset was still active after %0d cycles", waited);
            test_errors++;
            aborted = 1'b1;
        end
        else
        begin
            fd = $fopen("testbench/stats_trace.txt", "r");
            if (fd == 0)
            begin
                $display("Could not open the trace file testbench/stats_trace.txt");
                test_errors++;
                aborted = 1'b1;
            end
        end
        @(negedge clk);

        while (!aborted && $fscanf(fd, "%s", cmd) == 1)
        begin
            if (cmd == "#")
            begin
                needed = 1;
                fields = $fgets(rest, fd);
            end
            else if (cmd == "REQ")
            begin
                needed = 3;
                fields = $fscanf(fd, "%s %h %h", word, lines, count);
                repeat (count) send_request(word == "W", lines);
            end
            else if (cmd == "IDLE")
            begin
                needed = 1;
                fields = $fscanf(fd, "%h", count);
                repeat (count) step_cycle('0);
            end
            else if (cmd == "READ")
            begin
                needed = 2;
                fields = $fscanf(fd, "%h %h", idx, value);
                single_read(idx, value[cnt_bits-1:0]);
            end
            else if (cmd == "MODEL")
            begin
                needed = 1;
                fields = $fscanf(fd, "%h", idx);
                single_read(idx, model[idx]);
            end
            else if (cmd == "BURST")
            begin
                needed = 4;
                fields = $fscanf(fd, "%h %h %h %h", burst_values[0], burst_values[1],
                                 burst_values[2], burst_values[3]);
                burst_read();
            end
            else if (cmd == "STREAM")
            begin
                needed = 1;
                fields = $fscanf(fd, "%h", count);
                send_stream(count);
            end
            else if (cmd == "END")
            begin
                needed = 1;
                fields = $fscanf(fd, "%s", word);
                finish_test(word);
            end
            else
            begin
                $display("Unknown trace command %0s", cmd);
                test_errors++;
                aborted = 1'b1;
            end

            // A command whose arguments could not all be read leaves the trace unusable
            if (!aborted && fields < needed)
            begin
                $display("Trace command %0s is missing some of its arguments", cmd);
                test_errors++;
                aborted = 1'b1;
            end
        end

        if (fd != 0)
        begin
            $fclose(fd);
        end
        total_errors += test_errors;
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0 && tests_passed > 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- stats_top.f
+incdir+src
src/stats_pkg.sv
src/stats_counter_multicycle.sv
src/stats_event_decode.sv
src/stats_csr_read.sv
src/stats_top.sv
testbench/stats_clock_gen.sv
testbench/stats_props.sv
testbench/stats_tb.sv

//--- Makefile
# Verilator build of the statistics block testbench
# The run target fails unless the simulation log holds the pass line

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f stats_top.f \
		--top-module stats_tb -Mdir obj_dir -o stats_tb

run: compile
	./obj_dir/stats_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/stats_trace.txt
# One command per line and all numbers in hex
# REQ kind lines count / IDLE cycles / READ index value / BURST v0 v1 v2 v3 / STREAM events / MODEL index / END name
READ 0 0
READ 1 0
READ 2 0
READ 3 0
IDLE 4
END reset
REQ R 1 1
READ 0 1
READ 2 1
READ 1 0
REQ W 1 1
READ 1 1
READ 3 1
READ 0 1
END single_events
REQ R 2 1
REQ R 3 1
REQ R 4 1
REQ W 2 1
REQ W 3 1
REQ W 4 1
READ 0 4
READ 1 4
READ 2 a
READ 3 a
END line_counts
REQ R 4 64
READ 2 19a
READ 0 68
END carry
BURST 68 4 19a a
END read_timing
STREAM 40
MODEL 0
MODEL 1
MODEL 2
MODEL 3
END stream
